// ==== design/frame_pkg.sv ====
package frame_pkg;

	// ==================================================
	// on-wire frame format
	// ==================================================

	// byte index of the copy number, counted from frame start
	localparam int id_offset = 22;

	localparam int copy_count = 5; // copies sent per packet

	localparam int byte_w = 8;

	// ==================================================
	// input byte
	// ==================================================

	// one cycle of the receive stream, frame runs while en is high
	typedef struct packed {
		logic en;
		logic [byte_w-1:0] data;
	} rx_byte_t;

endpackage

// ==== design/vote_pkg.sv ====
package vote_pkg;

	// ==================================================
	// payload buffers
	// ==================================================

	localparam int addr_w = 8; // payload of at most 256 bytes

	// write stream shared by all buffers, sel picks the target
	typedef struct packed {
		logic valid;
		logic last; // final payload byte of the frame
		logic [addr_w-1:0] addr;
		logic [frame_pkg::byte_w-1:0] data;
	} buf_write_t;

	typedef struct packed {
		logic present;
		logic [addr_w:0] length; // 1..256 bytes
	} buf_status_t;

	// ==================================================
	// voted output stream
	// ==================================================

	typedef struct packed {
		logic valid;
		logic last;
		logic [frame_pkg::byte_w-1:0] data;
	} out_byte_t;

endpackage

// ==== design/frame_receiver.sv ====
`timescale 1ns/1ps

module frame_receiver (
	input logic clk,
	input logic reset,
	input frame_pkg::rx_byte_t rx,
	output vote_pkg::buf_write_t wr,
	output logic [frame_pkg::copy_count-1:0] sel,
	output logic round_done
);

	frame_pkg::rx_byte_t rx_q;
	logic [$clog2(frame_pkg::id_offset + 2)-1:0] byte_cnt; // saturates past the id
	logic id_byte;
	logic payload_byte;
	logic pend_valid;
	logic [vote_pkg::addr_w-1:0] pend_addr;
	logic [frame_pkg::byte_w-1:0] pend_data;

	// ==================================================
	// input register and byte position
	// ==================================================

	always_ff @(posedge clk) begin
		rx_q.data <= rx.data;
		if (reset) begin
			rx_q.en <= 1'b0;
		end else begin
			rx_q.en <= rx.en;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || !rx_q.en) begin
			byte_cnt <= '0;
		end else if (byte_cnt <= frame_pkg::id_offset) begin
			byte_cnt <= byte_cnt + 1'b1;
		end
	end

	assign id_byte = rx_q.en && (byte_cnt == frame_pkg::id_offset);
	assign payload_byte = rx_q.en && (byte_cnt > frame_pkg::id_offset) && (|sel);

	// one-hot copy select, copy numbers outside 1..5 select nothing
	always_ff @(posedge clk) begin
		if (reset) begin
			sel <= '0;
		end else if (id_byte) begin
			for (int i = 0; i < frame_pkg::copy_count; i++) begin
				sel[i] <= (rx_q.data[3:0] == 4'(i + 1)); // low nibble only
			end
		end else if ((wr.valid && wr.last) || (!rx_q.en && !pend_valid)) begin
			sel <= '0; // frame done, or ended with no payload
		end
	end

	// ==================================================
	// payload write stream
	// ==================================================

	// one byte held back so last is known when the frame ends
	always_ff @(posedge clk) begin
		if (payload_byte) begin
			pend_data <= rx_q.data;
			pend_addr <= pend_valid ? pend_addr + 1'b1 : '0;
		end
		if (reset) begin
			pend_valid <= 1'b0;
		end else begin
			pend_valid <= payload_byte;
		end
	end

	always_ff @(posedge clk) begin
		wr.addr <= pend_addr;
		wr.data <= pend_data;
		wr.last <= !rx_q.en; // en dropped behind the held byte
		if (reset) begin
			wr.valid <= 1'b0;
			round_done <= 1'b0;
		end else begin
			wr.valid <= pend_valid;
			round_done <= wr.valid && wr.last && sel[frame_pkg::copy_count-1];
		end
	end

	// a payload longer than the buffer would wrap onto address 0
	a_addr_no_wrap: assert property (@(posedge clk) disable iff (reset)
		wr.valid && !wr.last |=> wr.valid && (wr.addr != '0))
		else $error("payload write address wrapped within a frame");

endmodule

// ==== design/copy_buffer.sv ====
`timescale 1ns/1ps

module copy_buffer (
	input logic clk,
	input logic reset,
	input vote_pkg::buf_write_t wr,
	input logic sel,
	input logic round_done,
	input logic [vote_pkg::addr_w-1:0] rd_addr,
	output logic [frame_pkg::byte_w-1:0] rd_data,
	output vote_pkg::buf_status_t status
);

	logic [frame_pkg::byte_w-1:0] mem [2**vote_pkg::addr_w];
	logic wr_en;

	assign wr_en = wr.valid && sel; // broadcast stream, this copy only

	// ==================================================
	// payload memory, registered read
	// ==================================================

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr.addr] <= wr.data;
		end
		rd_data <= mem[rd_addr];
	end

	// ==================================================
	// present flag and length
	// ==================================================

	always_ff @(posedge clk) begin
		if (wr_en && wr.last) begin
			status.length <= {1'b0, wr.addr} + 1'b1;
		end
		if (reset) begin
			status.present <= 1'b0;
		end else if (wr_en && wr.last) begin
			status.present <= 1'b1;
		end else if (round_done) begin
			status.present <= 1'b0; // voter samples on the same edge
		end
	end

	// a second frame with the same copy number inside one round
	a_no_duplicate: assert property (@(posedge clk) disable iff (reset)
		sel |-> !status.present)
		else $error("duplicate copy written before round end");

endmodule

// ==== design/majority_voter.sv ====
`timescale 1ns/1ps

module majority_voter (
	input logic clk,
	input logic reset,
	input logic round_done,
	input vote_pkg::buf_status_t status [frame_pkg::copy_count],
	input logic [frame_pkg::byte_w-1:0] rd_data [frame_pkg::copy_count],
	output logic [vote_pkg::addr_w-1:0] rd_addr,
	output vote_pkg::out_byte_t out,
	output logic lost
);

	vote_pkg::buf_status_t st_q [frame_pkg::copy_count];
	logic vote_en; // length vote cycle
	logic len_found;
	logic [vote_pkg::addr_w:0] len_vote;
	logic [frame_pkg::copy_count-1:0] len_match;
	logic [vote_pkg::addr_w:0] len_q;
	logic [frame_pkg::copy_count-1:0] mask; // copies of the voted length
	logic bad_acc;
	logic rd_v; // rd_data holds byte rd_idx
	logic [vote_pkg::addr_w-1:0] rd_idx;
	logic rd_last;
	logic [frame_pkg::byte_w-1:0] byte_vote;
	logic byte_bad;

	// ==================================================
	// length vote
	// ==================================================

	always_comb begin
		logic [2:0] n;
		len_found = 1'b0;
		len_vote = '0;
		for (int i = 0; i < frame_pkg::copy_count; i++) begin
			n = '0;
			for (int j = 0; j < frame_pkg::copy_count; j++) begin
				if (st_q[j].present && (st_q[j].length == st_q[i].length)) begin
					n = n + 1'b1;
				end
			end
			if (st_q[i].present && (n > frame_pkg::copy_count / 2) && !len_found) begin
				len_found = 1'b1;
				len_vote = st_q[i].length;
			end
		end
		for (int i = 0; i < frame_pkg::copy_count; i++) begin
			len_match[i] = st_q[i].present && (st_q[i].length == len_vote);
		end
	end

	// ==================================================
	// byte vote
	// ==================================================

	always_comb begin
		logic [2:0] n;
		logic found;
		found = 1'b0;
		byte_vote = '0;
		for (int i = frame_pkg::copy_count - 1; i >= 0; i--) begin
			if (mask[i]) begin
				byte_vote = rd_data[i]; // lowest copy as fallback
			end
		end
		for (int i = 0; i < frame_pkg::copy_count; i++) begin
			n = '0;
			for (int j = 0; j < frame_pkg::copy_count; j++) begin
				if (mask[j] && (rd_data[j] == rd_data[i])) begin
					n = n + 1'b1;
				end
			end
			if (mask[i] && (n > frame_pkg::copy_count / 2) && !found) begin
				found = 1'b1;
				byte_vote = rd_data[i];
			end
		end
		byte_bad = 1'b0;
		for (int i = 0; i < frame_pkg::copy_count; i++) begin
			byte_bad = byte_bad || (mask[i] && (rd_data[i] != byte_vote));
		end
	end

	assign rd_last = ({1'b0, rd_idx} == len_q - 1'b1);

	// ==================================================
	// readout and output stream
	// ==================================================

	always_ff @(posedge clk) begin
		if (round_done) begin
			st_q <= status;
		end
		if (vote_en) begin
			len_q <= len_vote;
			mask <= len_match;
			bad_acc <= (len_match != '1); // missing copy or length mismatch
		end else if (rd_v) begin
			bad_acc <= bad_acc || byte_bad;
		end
		out.data <= byte_vote;
		out.last <= rd_last;
	end

	// rd_addr idles at 0 so byte 0 is already read when the vote lands
	always_ff @(posedge clk) begin
		if (reset) begin
			vote_en <= 1'b0;
			rd_v <= 1'b0;
			rd_idx <= '0;
			rd_addr <= '0;
			out.valid <= 1'b0;
			lost <= 1'b0;
		end else begin
			vote_en <= round_done;
			out.valid <= rd_v;
			lost <= (vote_en && !len_found) || (rd_v && rd_last && (bad_acc || byte_bad));
			if (vote_en && len_found) begin
				rd_v <= 1'b1;
				rd_idx <= '0;
				rd_addr <= rd_addr + 1'b1; // fetch one ahead
			end else if (rd_v) begin
				if (rd_last) begin
					rd_v <= 1'b0;
					rd_addr <= '0;
				end else begin
					rd_idx <= rd_idx + 1'b1;
					rd_addr <= rd_addr + 1'b1;
				end
			end
		end
	end

	a_no_overlap: assert property (@(posedge clk) disable iff (reset)
		vote_en |-> !rd_v)
		else $error("round closed while a readout is still running");

endmodule

// ==== design/redundant_frame_voter.sv ====
`timescale 1ns/1ps

module redundant_frame_voter (
	input logic clk,
	input logic reset,
	input frame_pkg::rx_byte_t rx,
	output vote_pkg::out_byte_t out,
	output logic lost
);

	vote_pkg::buf_write_t wr;
	logic [frame_pkg::copy_count-1:0] sel;
	logic round_done;
	logic [vote_pkg::addr_w-1:0] rd_addr;
	logic [frame_pkg::byte_w-1:0] rd_data [frame_pkg::copy_count];
	vote_pkg::buf_status_t status [frame_pkg::copy_count];

	frame_receiver u_frame_receiver (
		.clk(clk),
		.reset(reset),
		.rx(rx),
		.wr(wr),
		.sel(sel),
		.round_done(round_done)
	);

	// ==================================================
	// one buffer per copy number
	// ==================================================

	for (genvar i = 0; i < frame_pkg::copy_count; i++) begin : g_copy
		copy_buffer u_copy_buffer (
			.clk(clk),
			.reset(reset),
			.wr(wr),
			.sel(sel[i]),
			.round_done(round_done),
			.rd_addr(rd_addr), // shared, all copies read in parallel
			.rd_data(rd_data[i]),
			.status(status[i])
		);
	end

	majority_voter u_majority_voter (
		.clk(clk),
		.reset(reset),
		.round_done(round_done),
		.status(status),
		.rd_data(rd_data),
		.rd_addr(rd_addr),
		.out(out),
		.lost(lost)
	);

endmodule

// ==== verif/vote_checker.sv ====
`timescale 1ns/1ps

module vote_checker (
	input logic clk,
	input logic reset,
	input frame_pkg::rx_byte_t rx,
	input vote_pkg::out_byte_t out,
	input logic lost,
	output int errors,
	output int checks,
	output int pending
);

	logic [frame_pkg::byte_w-1:0] copy_mem [frame_pkg::copy_count][256];
	int copy_len [frame_pkg::copy_count]; // 0 while absent this round
	logic [10:0] exp_q [$]; // valid, last, lost, data
	logic [10:0] got;
	logic [10:0] exp;
	int pos;
	int id;

	// ==================================================
	// reference model
	// ==================================================

	task automatic predict;
		int vlen;
		int n;
		int pick;
		logic bad;
		vlen = 0;
		for (int i = 0; i < frame_pkg::copy_count; i++) begin
			n = 0;
			for (int j = 0; j < frame_pkg::copy_count; j++) begin
				n += (copy_len[j] == copy_len[i]);
			end
			if (copy_len[i] != 0 && n >= 3) begin
				vlen = copy_len[i];
			end
		end
		bad = (vlen == 0);
		for (int i = 0; i < frame_pkg::copy_count; i++) begin
			bad = bad || (copy_len[i] != vlen); // missing or other length
		end
		if (vlen == 0) begin
			exp_q.push_back(11'h100); // lone lost pulse
		end
		for (int a = 0; a < vlen; a++) begin
			pick = -1;
			for (int i = 0; i < frame_pkg::copy_count; i++) begin
				n = 0;
				for (int j = 0; j < frame_pkg::copy_count; j++) begin
					n += (copy_len[j] == vlen && copy_mem[j][a] == copy_mem[i][a]);
				end
				if (copy_len[i] == vlen && (pick < 0 || n >= 3)) begin
					pick = i; // lowest copy unless a majority shows up
				end
			end
			for (int i = 0; i < frame_pkg::copy_count; i++) begin
				bad = bad || (copy_len[i] == vlen && copy_mem[i][a] != copy_mem[pick][a]);
			end
			exp_q.push_back({1'b1, a == vlen - 1, bad && a == vlen - 1, copy_mem[pick][a]});
		end
	endtask

	// ==================================================
	// input monitor and output compare
	// ==================================================

	always @(posedge clk) begin
		if (reset) begin
			pos = 0;
			for (int i = 0; i < frame_pkg::copy_count; i++) begin
				copy_len[i] = 0;
			end
		end else if (rx.en) begin
			if (pos == frame_pkg::id_offset) begin
				id = rx.data[3:0];
			end else if (pos > frame_pkg::id_offset && id >= 1 && id <= frame_pkg::copy_count) begin
				copy_mem[id - 1][pos - frame_pkg::id_offset - 1] = rx.data;
			end
			pos++;
		end else begin
			if (pos > frame_pkg::id_offset + 1 && id >= 1 && id <= frame_pkg::copy_count) begin
				copy_len[id - 1] = pos - frame_pkg::id_offset - 1;
				if (id == frame_pkg::copy_count) begin
					predict();
					for (int i = 0; i < frame_pkg::copy_count; i++) begin
						copy_len[i] = 0; // next round starts empty
					end
				end
			end
			pos = 0;
		end
	end

	always @(negedge clk) begin
		if (!reset && (out.valid || lost)) begin
			got = {out.valid, out.valid && out.last, lost, out.valid ? out.data : 8'h00};
			checks++;
			if (exp_q.size() == 0) begin
				errors++;
				$display("MISMATCH at %0d ns: output with no round pending, valid %b lost %b data %h",
					$time, got[10], got[8], got[7:0]);
			end else begin
				exp = exp_q.pop_front();
				if (got != exp) begin
					errors++;
					$display("MISMATCH at %0d ns: expected v/last/lost %b%b%b data %h, got %b%b%b data %h",
						$time, exp[10], exp[9], exp[8], exp[7:0], got[10], got[9], got[8], got[7:0]);
				end
			end
		end
		pending = exp_q.size();
	end

endmodule

// ==== verif/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

	localparam int round_count = 40;
	localparam int result_timeout = 200; // longest payload plus pipeline

	logic clk;
	logic reset;
	frame_pkg::rx_byte_t rx;
	vote_pkg::out_byte_t out;
	logic lost;
	int errors; // checker mismatches
	int checks;
	int pending;
	int failures; // timeouts and outputs that never came
	int seed;
	logic [frame_pkg::byte_w-1:0] payload [64];

	redundant_frame_voter u_redundant_frame_voter (.*);

	vote_checker u_vote_checker (.*);

	always #10 clk = ~clk;

	// ==================================================
	// frame driver
	// ==================================================

	// idle gap, header bytes, id byte, then payload
	task automatic send_frame(input logic [7:0] id, input int nbytes, input bit corrupt);
		rx.en = 1'b0;
		repeat (1 + $urandom % 3) @(negedge clk);
		for (int k = 0; k < nbytes; k++) begin
			rx.en = 1'b1;
			if (k < frame_pkg::id_offset) begin
				rx.data = 8'($urandom);
			end else if (k == frame_pkg::id_offset) begin
				rx.data = id;
			end else begin
				rx.data = payload[k - frame_pkg::id_offset - 1];
				if (corrupt && $urandom % 4 == 0) begin
					rx.data = rx.data ^ (8'h01 << ($urandom % 8)); // flip one bit
				end
			end
			@(negedge clk);
		end
		rx.en = 1'b0;
	endtask

	task automatic run_round(input int kind);
		int plen;
		int clen [frame_pkg::copy_count];
		bit skip [frame_pkg::copy_count];
		bit corrupt [frame_pkg::copy_count];
		int cycles;
		plen = (kind == 3) ? 2 + $urandom % 63 : 1 + $urandom % 64;
		foreach (payload[a]) begin
			payload[a] = 8'($urandom);
		end
		for (int c = 0; c < frame_pkg::copy_count; c++) begin
			clen[c] = plen;
			skip[c] = 1'b0;
			corrupt[c] = 1'b0;
		end
		case (kind)
			1: begin // one or two damaged copies
				corrupt[$urandom % 5] = 1'b1;
				corrupt[$urandom % 5] = 1'b1;
			end
			2: begin // copy 1, copy 3 or both left out
				skip[0] = $urandom % 2;
				skip[2] = !skip[0] || ($urandom % 2);
			end
			3: begin
				repeat (2 + $urandom % 2) begin
					clen[$urandom % 5] = 1 + $urandom % (plen - 1); // cut short
				end
			end
			default: ;
		endcase
		for (int c = 0; c < frame_pkg::copy_count; c++) begin
			if (kind == 4) begin
				case ($urandom % 3)
					0: send_frame(8'h00, 1 + $urandom % frame_pkg::id_offset, 1'b0);
					1: send_frame(8'h37, frame_pkg::id_offset + 1 + clen[c], 1'b0); // copy 7
					default: send_frame(8'hc0, frame_pkg::id_offset + 1 + clen[c], 1'b0);
				endcase
			end
			if (!skip[c]) begin
				send_frame({4'($urandom), 4'(c + 1)}, frame_pkg::id_offset + 1 + clen[c],
					corrupt[c]);
			end
		end
		// wait for last or a lone lost pulse
		cycles = 0;
		while (!((out.valid && out.last) || lost) && cycles < result_timeout) begin
			@(negedge clk);
			cycles++;
		end
		if (!((out.valid && out.last) || lost)) begin
			failures++;
			$display("timeout: no result for a round of kind %0d after %0d cycles", kind, cycles);
		end
	endtask

	// ==================================================
	// main sequence
	// ==================================================

	initial begin
		seed = 32'h50a1;
		seed = $urandom(seed);
		clk = 1'b0;
		reset = 1'b1;
		rx = '0;
		failures = 0;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		for (int r = 0; r < round_count && failures == 0; r++) begin
			run_round(r % 5);
		end
		repeat (10) @(negedge clk); // room for stray output
		if (pending != 0) begin
			failures++;
			$display("%0d expected output items never appeared", pending);
		end
		$display("checks %0d, mismatches %0d, other failures %0d", checks, errors, failures);
		if (errors == 0 && failures == 0 && checks > 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
design/frame_pkg.sv
design/vote_pkg.sv
design/frame_receiver.sv
design/copy_buffer.sv
design/majority_voter.sv
design/redundant_frame_voter.sv
verif/vote_checker.sv
verif/tb_top.sv
